//--- fetch_unit.f
hdl/fetch_pkg.sv
hdl/fetch_pointer.sv
hdl/prefetch_bus.sv
hdl/byte_fifo.sv
hdl/immediate_reader.sv
hdl/fetch_unit.sv
test/fetch_unit_tb.sv

//--- hdl/byte_fifo.sv
// Circular prefetch queue with flush and a nearly-full level used for fetch back-pressure
`default_nettype none
`timescale 1ns/10ps

module byte_fifo #(
    parameter int data_width = 8,
    parameter int depth = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    wr_en,
    input  logic [data_width-1:0]   wr_data,
    input  logic                    rd_en,
    output logic [data_width-1:0]   rd_data,
    output logic                    empty,
    output logic                    nearly_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    logic [data_width-1:0] mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [count_w-1:0] count;
    logic do_wr;
    logic do_rd;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    assign empty       = count == '0;
    assign nearly_full = count >= count_w'(depth - fetch_pkg::QUEUE_SLACK);

    // Head entry shown without a read strobe
    assign rd_data = mem[rd_ptr];

    assign do_wr = wr_en && (count != count_w'(depth));
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            unique case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Writer must honour nearly_full early enough, reader must check empty
    no_write_when_full: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> count != count_w'(depth)
    );
    no_read_when_empty: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    );

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
// Shared types and constants for the instruction fetch front end, referenced by scoped name
`default_nettype none

package fetch_pkg;

    // Physical address is segment * 16 + offset, modulo 2^20
    localparam int PHYS_ADDR_W = 20;

    // Instruction bus carries word addresses only
    localparam int BUS_ADDR_W = 19;

    // Prefetch byte queue sizing
    localparam int QUEUE_DEPTH = 6;

    // Room kept for both bytes of a word that is still in flight
    localparam int QUEUE_SLACK = 2;

    // CS:IP pair loaded into the fetch pointer
    typedef struct packed {
        logic [15:0] cs;
        logic [15:0] ip;
    } fetch_addr_t;

    // Instruction bus master states
    typedef enum logic [1:0] {
        PF_REQUEST,
        PF_WAIT_ACK,
        PF_PUSH_LOW,
        PF_PUSH_HIGH
    } prefetch_state_t;

    // Immediate reader states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LOW,
        RD_HIGH
    } reader_state_t;

endpackage

`default_nettype wire

//--- hdl/fetch_pointer.sv
// Holds the CS:IP fetch pointer, advances it per prefetched byte and raises flush on a load
`default_nettype none
`timescale 1ns/10ps

module fetch_pointer (
    input  logic                                clk,
    input  logic                                rst,
    input  fetch_pkg::fetch_addr_t              load_addr,
    input  logic                                load_en,
    input  logic                                byte_pushed,
    output logic [fetch_pkg::PHYS_ADDR_W-1:0]   phys_addr,
    output logic                                flush
);

    // Current segment and the offset of the next byte to prefetch
    fetch_pkg::fetch_addr_t ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (load_en) begin
            // A new CS:IP takes priority over the byte counter
            ptr <= load_addr;
        end else if (byte_pushed) begin
            // Offset wraps inside the segment
            ptr.ip <= ptr.ip + 16'd1;
        end
    end

    // Flush follows the load by one cycle so the new address is already visible
    always_ff @(posedge clk) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= load_en;
        end
    end

    // Segment shifted by four plus the offset with the carry out of bit 19 dropped
    assign phys_addr = {ptr.cs, 4'h0} + {4'h0, ptr.ip};

    // A byte of the old stream never advances a freshly loaded offset
    load_wins_over_push: assert property (
        @(posedge clk) disable iff (rst)
        flush |-> !byte_pushed
    );

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
// Top level of the fetch front end: pointer, bus master, byte queue and immediate reader
`default_nettype none
`timescale 1ns/10ps

module fetch_unit (
    input  logic                                clk,
    input  logic                                rst,

    // Fetch address load
    input  fetch_pkg::fetch_addr_t              load_addr,
    input  logic                                load_en,

    // Instruction bus
    output logic [fetch_pkg::BUS_ADDR_W-1:0]    instr_m_addr,
    input  logic [15:0]                         instr_m_data_in,
    output logic                                instr_m_access,
    input  logic                                instr_m_ack,

    // Immediate port
    input  logic                                immed_start,
    input  logic                                immed_is_8bit,
    output logic                                immed_complete,
    output logic [15:0]                         immediate
);

    logic [fetch_pkg::PHYS_ADDR_W-1:0] phys_addr;
    logic flush;
    logic byte_pushed;
    logic queue_wr_en;
    logic [7:0] queue_wr_data;
    logic queue_rd_en;
    logic [7:0] queue_rd_data;
    logic queue_empty;
    logic queue_nearly_full;

    fetch_pointer pointer0 (
        .clk         (clk),
        .rst         (rst),
        .load_addr   (load_addr),
        .load_en     (load_en),
        .byte_pushed (byte_pushed),
        .phys_addr   (phys_addr),
        .flush       (flush)
    );

    prefetch_bus prefetch0 (
        .clk               (clk),
        .rst               (rst),
        .phys_addr         (phys_addr),
        .flush             (flush),
        .queue_nearly_full (queue_nearly_full),
        .instr_m_addr      (instr_m_addr),
        .instr_m_data_in   (instr_m_data_in),
        .instr_m_access    (instr_m_access),
        .instr_m_ack       (instr_m_ack),
        .queue_wr_en       (queue_wr_en),
        .queue_wr_data     (queue_wr_data),
        .byte_pushed       (byte_pushed)
    );

    byte_fifo #(
        .data_width (8),
        .depth      (fetch_pkg::QUEUE_DEPTH)
    ) queue0 (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .wr_en       (queue_wr_en),
        .wr_data     (queue_wr_data),
        .rd_en       (queue_rd_en),
        .rd_data     (queue_rd_data),
        .empty       (queue_empty),
        .nearly_full (queue_nearly_full)
    );

    immediate_reader reader0 (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .start        (immed_start),
        .is_8bit      (immed_is_8bit),
        .fifo_rd_en   (queue_rd_en),
        .fifo_rd_data (queue_rd_data),
        .fifo_empty   (queue_empty),
        .complete     (immed_complete),
        .immediate    (immediate)
    );

endmodule

`default_nettype wire

//--- hdl/immediate_reader.sv
// Pops one or two bytes from the prefetch queue and returns them as a little-endian immediate
`default_nettype none
`timescale 1ns/10ps

module immediate_reader (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        start,
    input  logic        is_8bit,
    output logic        fifo_rd_en,
    input  logic [7:0]  fifo_rd_data,
    input  logic        fifo_empty,
    output logic        complete,
    output logic [15:0] immediate
);

    fetch_pkg::reader_state_t state;
    logic is_8bit_q;
    logic [7:0] low_q;
    logic want_8bit;
    logic pop_low;
    logic pop_high;

    // Size comes straight from the port in the start cycle
    assign want_8bit = (state == fetch_pkg::RD_IDLE) ? is_8bit : is_8bit_q;

    // Low byte can be taken in the start cycle itself
    assign pop_low = (((state == fetch_pkg::RD_IDLE) && start) || (state == fetch_pkg::RD_LOW))
                     && !fifo_empty && !flush;
    assign pop_high = (state == fetch_pkg::RD_HIGH) && !fifo_empty && !flush;

    assign fifo_rd_en = pop_low || pop_high;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::RD_IDLE;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (flush) begin
                // Abort quietly, a start in this cycle waits for new bytes
                state <= start ? fetch_pkg::RD_LOW : fetch_pkg::RD_IDLE;
            end else begin
                unique case (state)
                    fetch_pkg::RD_IDLE, fetch_pkg::RD_LOW: begin
                        if (pop_low) begin
                            state    <= want_8bit ? fetch_pkg::RD_IDLE : fetch_pkg::RD_HIGH;
                            complete <= want_8bit;
                        end else if (start) begin
                            state <= fetch_pkg::RD_LOW;
                        end
                    end
                    fetch_pkg::RD_HIGH: begin
                        if (pop_high) begin
                            state    <= fetch_pkg::RD_IDLE;
                            complete <= 1'b1;
                        end
                    end
                    default: begin
                        state <= fetch_pkg::RD_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == fetch_pkg::RD_IDLE) && start) begin
            is_8bit_q <= is_8bit;
        end
        if (pop_low) begin
            low_q <= fifo_rd_data;
        end
        // Result changes only together with complete
        if (pop_low && want_8bit) begin
            immediate <= {8'h00, fifo_rd_data};
        end else if (pop_high) begin
            immediate <= {fifo_rd_data, low_q};
        end
    end

    // Requester waits for complete before asking again
    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> state == fetch_pkg::RD_IDLE
    );

endmodule

`default_nettype wire

//--- hdl/prefetch_bus.sv
// Instruction bus master that fetches words at the fetch pointer and feeds their bytes to the queue
`default_nettype none
`timescale 1ns/10ps

module prefetch_bus (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [fetch_pkg::PHYS_ADDR_W-1:0]   phys_addr,
    input  logic                                flush,
    input  logic                                queue_nearly_full,
    output logic [fetch_pkg::BUS_ADDR_W-1:0]    instr_m_addr,
    input  logic [15:0]                         instr_m_data_in,
    output logic                                instr_m_access,
    input  logic                                instr_m_ack,
    output logic                                queue_wr_en,
    output logic [7:0]                          queue_wr_data,
    output logic                                byte_pushed
);

    fetch_pkg::prefetch_state_t state;

    // Word of the access in flight belongs to a stale stream
    logic discard;

    // Request address and byte lane held for the whole access
    logic [fetch_pkg::BUS_ADDR_W-1:0] req_addr;
    logic req_odd;

    logic [15:0] word;
    logic start_req;
    logic pushing;

    // No new request while the queue cannot take a whole word
    assign start_req = (state == fetch_pkg::PF_REQUEST) && !queue_nearly_full;

    assign instr_m_addr   = req_addr;
    assign instr_m_access = state == fetch_pkg::PF_WAIT_ACK;

    assign pushing = (state == fetch_pkg::PF_PUSH_LOW) || (state == fetch_pkg::PF_PUSH_HIGH);

    // Bytes of the old stream are dropped in the flush cycle
    assign queue_wr_en   = pushing && !flush;
    assign byte_pushed   = queue_wr_en;
    assign queue_wr_data = (state == fetch_pkg::PF_PUSH_HIGH) ? word[15:8] : word[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= fetch_pkg::PF_REQUEST;
            discard <= 1'b0;
        end else begin
            unique case (state)
                fetch_pkg::PF_REQUEST: begin
                    if (start_req) begin
                        state <= fetch_pkg::PF_WAIT_ACK;
                    end
                end
                fetch_pkg::PF_WAIT_ACK: begin
                    if (instr_m_ack) begin
                        discard <= 1'b0;
                        if (discard || flush) begin
                            state <= fetch_pkg::PF_REQUEST;
                        end else if (req_odd) begin
                            // Odd address starts in the high byte
                            state <= fetch_pkg::PF_PUSH_HIGH;
                        end else begin
                            state <= fetch_pkg::PF_PUSH_LOW;
                        end
                    end else if (flush) begin
                        // Keep access up until the ack, then throw the word away
                        discard <= 1'b1;
                    end
                end
                fetch_pkg::PF_PUSH_LOW: begin
                    state <= flush ? fetch_pkg::PF_REQUEST : fetch_pkg::PF_PUSH_HIGH;
                end
                fetch_pkg::PF_PUSH_HIGH: begin
                    state <= fetch_pkg::PF_REQUEST;
                end
                default: begin
                    state <= fetch_pkg::PF_REQUEST;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            req_addr <= phys_addr[fetch_pkg::PHYS_ADDR_W-1:1];
            req_odd  <= phys_addr[0];
        end
        // Data is only valid in the ack cycle
        if (instr_m_access && instr_m_ack) begin
            word <= instr_m_data_in;
        end
    end

    // Bus rule: access and address hold until the slave acks
    access_held_until_ack: assert property (
        @(posedge clk) disable iff (rst)
        instr_m_access && !instr_m_ack |=> instr_m_access && $stable(instr_m_addr)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the fetch_unit testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f fetch_unit.f \
    --top-module fetch_unit_tb \
    -o fetch_unit_sim

./obj_dir/fetch_unit_sim | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "fetch_unit: test passed"
else
    echo "fetch_unit: test failed"
    exit 1
fi

//--- test/fetch_unit_tb.sv
// Random-stimulus testbench for fetch_unit with memory and byte-stream models, run by run_sim.sh
`default_nettype none
`timescale 1ns/10ps

module fetch_unit_tb;

    localparam logic [31:0] seed = 32'h51af9338;
    localparam int timeout_cycles = 200;
    localparam int max_access_cycles = 10;

    logic clk;
    logic rst;
    fetch_pkg::fetch_addr_t load_addr;
    logic load_en;
    logic [fetch_pkg::BUS_ADDR_W-1:0] instr_m_addr;
    logic [15:0] instr_m_data_in;
    logic instr_m_access;
    logic instr_m_ack;
    logic immed_start;
    logic immed_is_8bit;
    logic immed_complete;
    logic [15:0] immediate;

    // Reference cursor whose offset wraps inside its segment
    logic [15:0] model_cs;
    logic [15:0] model_ip;

    logic [31:0] stim_state;
    logic [31:0] bus_state;

    fetch_unit dut0 (
        .clk             (clk),
        .rst             (rst),
        .load_addr       (load_addr),
        .load_en         (load_en),
        .instr_m_addr    (instr_m_addr),
        .instr_m_data_in (instr_m_data_in),
        .instr_m_access  (instr_m_access),
        .instr_m_ack     (instr_m_ack),
        .immed_start     (immed_start),
        .immed_is_8bit   (immed_is_8bit),
        .immed_complete  (immed_complete),
        .immediate       (immediate)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper half only since the low LCG bits repeat too quickly
    function automatic logic [15:0] stim_rand();
        stim_state = lcg_step(stim_state);
        return stim_state[31:16];
    endfunction

    // Fixed instruction memory contents with one word per bus address
    function automatic logic [15:0] mem_word(input logic [fetch_pkg::BUS_ADDR_W-1:0] addr);
        logic [31:0] h;
        h = {13'h0000, addr} * 32'h9e3779b1;
        return h[31:16] ^ h[15:0] ^ {addr[2:0], addr[18:6]};
    endfunction

    function automatic logic [7:0] mem_byte(input logic [fetch_pkg::PHYS_ADDR_W-1:0] phys);
        logic [15:0] w;
        w = mem_word(phys[fetch_pkg::PHYS_ADDR_W-1:1]);
        return phys[0] ? w[15:8] : w[7:0];
    endfunction

    // Byte under the cursor before the offset steps on
    function automatic logic [7:0] model_next_byte();
        logic [31:0] linear;
        logic [fetch_pkg::PHYS_ADDR_W-1:0] phys;
        // Physical address wraps at 1 MiB
        linear = {16'h0000, model_cs} * 32'd16 + {16'h0000, model_ip};
        phys = linear[fetch_pkg::PHYS_ADDR_W-1:0];
        model_ip = model_ip + 16'd1;
        return mem_byte(phys);
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic read_immediate(input logic is_8bit);
        logic [7:0] lo;
        logic [7:0] hi;
        int waited;
        lo = model_next_byte();
        hi = 8'h00;
        if (!is_8bit) begin
            hi = model_next_byte();
        end
        waited = 0;
        immed_start = 1'b1;
        immed_is_8bit = is_8bit;
        next_cycle();
        immed_start = 1'b0;
        // Size must have been sampled with start
        immed_is_8bit = ~is_8bit;
        while (!immed_complete) begin
            if (waited >= timeout_cycles) begin
                $display("error at %0t ns: no immed_complete within %0d cycles of immed_start",
                         $time, timeout_cycles);
                abort_run();
            end
            next_cycle();
            waited++;
        end
        check_value("immediate", {16'h0000, immediate}, {16'h0000, hi, lo});
    endtask

    task automatic random_reads(input int count);
        logic [15:0] r;
        for (int i = 0; i < count; i++) begin
            r = stim_rand();
            read_immediate(r[0]);
            idle_cycles(int'(r[5:4]));
        end
    endtask

    task automatic load_pointer(input logic [15:0] cs, input logic [15:0] ip);
        load_addr.cs = cs;
        load_addr.ip = ip;
        load_en = 1'b1;
        next_cycle();
        load_en = 1'b0;
        // Queue and reader restart in the flush cycle
        next_cycle();
        model_cs = cs;
        model_ip = ip;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Instruction memory that acks each access after 0 to 3 wait cycles
    initial begin : memory_model
        int delay;
        int access_run;
        bit waiting;
        instr_m_ack = 1'b0;
        instr_m_data_in = 16'h0000;
        delay = 0;
        access_run = 0;
        waiting = 1'b0;
        // Own random stream for the bus side
        bus_state = ~seed;
        forever begin
            next_cycle();
            instr_m_ack = 1'b0;
            instr_m_data_in = 16'h0000;
            if (instr_m_access) begin
                access_run++;
                if (access_run > max_access_cycles) begin
                    $display("error at %0t ns: instr_m_access held high for more than %0d cycles",
                             $time, max_access_cycles);
                    abort_run();
                end
                if (!waiting) begin
                    bus_state = lcg_step(bus_state);
                    delay = int'(bus_state[31:30]);
                    waiting = 1'b1;
                end
                if (delay == 0) begin
                    instr_m_ack = 1'b1;
                    instr_m_data_in = mem_word(instr_m_addr);
                    waiting = 1'b0;
                end else begin
                    delay--;
                end
            end else begin
                access_run = 0;
            end
        end
    end

    initial begin : stimulus
        logic [15:0] r;
        logic [15:0] cs_r;
        logic [15:0] ip_r;
        stim_state = seed;
        rst = 1'b1;
        load_addr = '0;
        load_en = 1'b0;
        immed_start = 1'b0;
        immed_is_8bit = 1'b0;
        model_cs = 16'h0000;
        model_ip = 16'h0000;
        idle_cycles(5);
        rst = 1'b0;

        // Byte stream from physical address 0
        for (int i = 0; i < 12; i++) begin
            read_immediate(1'b1);
        end

        // Word reads from an even cursor and then from an odd one
        for (int i = 0; i < 8; i++) begin
            read_immediate(1'b0);
        end
        read_immediate(1'b1);
        for (int i = 0; i < 8; i++) begin
            read_immediate(1'b0);
        end

        // Loads at random points that often fall while a word is in flight
        for (int i = 0; i < 12; i++) begin
            r = stim_rand();
            idle_cycles(int'(r[2:0]));
            cs_r = stim_rand();
            ip_r = stim_rand();
            load_pointer(cs_r, ip_r);
            random_reads(4);
        end

        // Queue fills during a long gap and fetching must stop
        idle_cycles(60);
        for (int i = 0; i < 20; i++) begin
            check_value("instr_m_access", {31'h0, instr_m_access}, 32'h0);
            next_cycle();
        end
        random_reads(16);

        // Offset wrap stays in the same segment
        cs_r = stim_rand();
        load_pointer(cs_r, 16'hfffe);
        read_immediate(1'b1);
        read_immediate(1'b1);
        read_immediate(1'b1);
        load_pointer(cs_r, 16'hffff);
        read_immediate(1'b0);

        // Mixed loads and reads
        for (int i = 0; i < 40; i++) begin
            r = stim_rand();
            if (r[3:0] == 4'h0) begin
                cs_r = stim_rand();
                ip_r = stim_rand();
                load_pointer(cs_r, ip_r);
            end else begin
                read_immediate(r[4]);
            end
            idle_cycles(int'(r[6:5]));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
